// ==== hdl/ex_pkg.sv ====
/*
  Shared definitions of the execute stage
  Enum encodings are fixed; decode must drive the same values
  SHAMT_W stays at 5 also for a 64-bit datapath, shifts then only
  reach the low 32 positions
*/

`default_nettype none

package ex_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Register file address
  localparam int unsigned REGADDR_W = 5;

  // Shift amount taken from operand B
  localparam int unsigned SHAMT_W = 5;

  ////////////////////
  // Operators
  ////////////////////

  // ALU operators, the last six are branch comparisons
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  // Multiplier operators
  // Low word, high signed x signed, high unsigned x unsigned, high signed x unsigned
  typedef enum logic [1:0] {
    MUL_LO,
    MUL_H,
    MUL_HU,
    MUL_HSU
  } mul_op_e;

  // Multiplier FSM
  typedef enum logic [0:0] {
    MULT_IDLE,
    MULT_DONE
  } mult_state_e;

endpackage

`default_nettype wire

// ==== hdl/ex_unit_if.sv ====
/*
  Result and status bundle of the functional units
  XLEN must match the modules that connect to it
*/

`default_nettype none

interface ex_unit_if #(
  parameter int unsigned XLEN = 32
);

  // ALU outputs
  logic [XLEN-1:0] alu_result;
  logic            cmp_result;

  // Multiplier outputs and handshake status
  logic [XLEN-1:0] mul_result;
  logic            mul_valid;
  logic            mul_ready;

  // Producers
  modport alu  (output alu_result, output cmp_result);
  modport mult (output mul_result, output mul_valid, output mul_ready);

  // Consumers
  modport ctrl (input mul_valid, input mul_ready);
  modport wb   (input alu_result, input cmp_result, input mul_result);

endinterface

`default_nettype wire

// ==== hdl/ex_alu.sv ====
/*
  Single-cycle ALU with branch comparison
  Purely combinational, no valid or ready of its own
  Shift amount is the low SHAMT_W bits of operand B, so with XLEN = 64
  shifts only reach the low 32 positions
  cmp_result is 0 for every non-branch operator
*/

`default_nettype none

module ex_alu import ex_pkg::*; #(
  parameter int unsigned XLEN = 32
) (
  input  alu_op_e         op_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,
  ex_unit_if.alu          unit_if
);

  logic [SHAMT_W-1:0] shamt;
  logic [XLEN-1:0]    add_res;
  logic [XLEN-1:0]    sub_res;
  logic [XLEN-1:0]    sra_res;
  logic               eq;
  logic               lt_s;
  logic               lt_u;
  logic               cmp;
  logic [XLEN-1:0]    result;

  ////////////////////
  // Datapath
  ////////////////////

  assign shamt   = operand_b_i[SHAMT_W-1:0];
  assign add_res = operand_a_i + operand_b_i;
  assign sub_res = operand_a_i - operand_b_i;

  // Arithmetic shift keeps the sign of operand A
  assign sra_res = $signed(operand_a_i) >>> shamt;

  // Comparators shared by SLT and the branches
  assign eq   = (operand_a_i == operand_b_i);
  assign lt_s = ($signed(operand_a_i) < $signed(operand_b_i));
  assign lt_u = (operand_a_i < operand_b_i);

  ////////////////////
  // Branch decision
  ////////////////////

  always_comb begin
    unique case (op_i)
      ALU_EQ:  cmp = eq;
      ALU_NE:  cmp = !eq;
      ALU_LT:  cmp = lt_s;
      ALU_GE:  cmp = !lt_s;
      ALU_LTU: cmp = lt_u;
      ALU_GEU: cmp = !lt_u;
      // Arithmetic and logic ops never take a branch
      default: cmp = 1'b0;
    endcase
  end

  ////////////////////
  // Result mux
  ////////////////////

  always_comb begin
    unique case (op_i)
      ALU_ADD:  result = add_res;
      ALU_SUB:  result = sub_res;
      ALU_AND:  result = operand_a_i & operand_b_i;
      ALU_OR:   result = operand_a_i | operand_b_i;
      ALU_XOR:  result = operand_a_i ^ operand_b_i;
      ALU_SLL:  result = operand_a_i << shamt;
      ALU_SRL:  result = operand_a_i >> shamt;
      ALU_SRA:  result = sra_res;
      ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_u};
      // Branch comparisons return the decision as 0 or 1
      default:  result = {{(XLEN-1){1'b0}}, cmp};
    endcase
  end

  assign unit_if.alu_result = result;
  assign unit_if.cmp_result = cmp;

endmodule

`default_nettype wire

// ==== hdl/ex_mult.sv ====
/*
  Two-cycle multiplier
  Product is computed in the start cycle and the selected word is held
  in MULT_DONE until ready_i or kill_i
  op_i and the operands need only be stable in the start cycle
  start_i must already be gated with kill and halt
*/

`default_nettype none

module ex_mult import ex_pkg::*; #(
  parameter int unsigned XLEN = 32
) (
  input  logic            clk,
  input  logic            rst_n,
  input  mul_op_e         op_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,
  input  logic            start_i,
  input  logic            ready_i,
  input  logic            kill_i,
  ex_unit_if.mult         unit_if
);

  mult_state_e              state_q;
  mult_state_e              state_d;
  logic                     a_signed;
  logic                     b_signed;
  logic signed [XLEN:0]     a_ext;
  logic signed [XLEN:0]     b_ext;
  logic signed [2*XLEN+1:0] product;
  logic [XLEN-1:0]          prod_word;
  logic [XLEN-1:0]          result_q;

  ////////////////////
  // Product
  ////////////////////

  // Only MULHU treats A as unsigned, only MUL and MULH treat B as signed
  assign a_signed = (op_i != MUL_HU);
  assign b_signed = (op_i == MUL_H) || (op_i == MUL_LO);

  // One extra bit covers the unsigned case with a signed multiplier
  assign a_ext   = {a_signed & operand_a_i[XLEN-1], operand_a_i};
  assign b_ext   = {b_signed & operand_b_i[XLEN-1], operand_b_i};
  assign product = a_ext * b_ext;

  assign prod_word = (op_i == MUL_LO) ? product[XLEN-1:0] : product[2*XLEN-1:XLEN];

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      MULT_IDLE: if (start_i) state_d = MULT_DONE;
      MULT_DONE: if (ready_i || kill_i) state_d = MULT_IDLE;
      default:   state_d = MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Result captured once per operation and held while WB stalls
  always_ff @(posedge clk) begin
    if ((state_q == MULT_IDLE) && start_i) begin
      result_q <= prod_word;
    end
  end

  assign unit_if.mul_result = result_q;
  assign unit_if.mul_valid  = (state_q == MULT_DONE);
  // Busy in the start cycle, then follows the downstream ready
  assign unit_if.mul_ready  = (state_q == MULT_IDLE) ? !start_i : ready_i;

endmodule

`default_nettype wire

// ==== hdl/ex_ctrl.sv ====
/*
  Stage control of EX
  Purely combinational, decisions are made in the same cycle
  Kill makes the stage ready and drops its valid
  Halt holds the instruction in EX with both valid and ready low
*/

`default_nettype none

module ex_ctrl (
  input  logic   id_valid_i,
  input  logic   alu_en_i,
  input  logic   mul_en_i,
  input  logic   illegal_i,
  input  logic   kill_i,
  input  logic   halt_i,
  input  logic   wb_ready_i,
  output logic   mul_start_o,
  output logic   ex_valid_o,
  output logic   ex_ready_o,
  ex_unit_if.ctrl unit_if
);

  logic instr_live;
  logic unit_valid;

  ////////////////////
  // Live instruction
  ////////////////////

  // Decode valid not killed or halted
  assign instr_live = id_valid_i && !kill_i && !halt_i;

  // Multiplier only starts on a live instruction
  assign mul_start_o = mul_en_i && instr_live;

  ////////////////////
  // Valid and ready
  ////////////////////

  // ALU results are ready at once
  // Illegal instructions pass as a bubble without a write
  assign unit_valid = alu_en_i || (mul_en_i && unit_if.mul_valid) || illegal_i;

  assign ex_valid_o = unit_valid && instr_live;

  // Kill always frees the stage
  assign ex_ready_o = kill_i || (wb_ready_i && unit_if.mul_ready && !halt_i);

endmodule

`default_nettype wire

// ==== hdl/ex_wb_reg.sv ====
/*
  Result select and EX/WB pipeline register
  A transfer happens on ex_valid_i and wb_ready_i, a bubble on
  wb_ready_i alone; all outputs hold while wb_ready_i is low
  Data, address and PC are only meaningful while wb_valid_o is high
*/

`default_nettype none

module ex_wb_reg import ex_pkg::*; #(
  parameter int unsigned XLEN = 32
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 ex_valid_i,
  input  logic                 wb_ready_i,
  input  logic                 mul_en_i,
  input  logic                 illegal_i,
  input  logic                 alu_bch_i,
  input  logic                 rf_we_i,
  input  logic [REGADDR_W-1:0] rf_waddr_i,
  input  logic [XLEN-1:0]      pc_i,
  ex_unit_if.wb                unit_if,
  output logic [XLEN-1:0]      rf_wdata_o,
  output logic                 wb_valid_o,
  output logic                 wb_rf_we_o,
  output logic [REGADDR_W-1:0] wb_rf_waddr_o,
  output logic [XLEN-1:0]      wb_rf_wdata_o,
  output logic [XLEN-1:0]      wb_pc_o,
  output logic                 wb_illegal_o,
  output logic                 wb_bch_taken_o
);

  logic            xfer;
  logic [XLEN-1:0] wdata_sel;

  ////////////////////
  // Result select
  ////////////////////

  // Ungated enable is enough, the write enable drops invalid results later
  assign wdata_sel  = mul_en_i ? unit_if.mul_result : unit_if.alu_result;
  // Forwarded to decode in the same cycle
  assign rf_wdata_o = wdata_sel;

  assign xfer = ex_valid_i && wb_ready_i;

  ////////////////////
  // EX/WB register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_o     <= 1'b0;
      wb_rf_we_o     <= 1'b0;
      wb_illegal_o   <= 1'b0;
      wb_bch_taken_o <= 1'b0;
    end else if (xfer) begin
      wb_valid_o     <= 1'b1;
      // Illegal instructions never write the register file
      wb_rf_we_o     <= rf_we_i && !illegal_i;
      wb_illegal_o   <= illegal_i;
      wb_bch_taken_o <= alu_bch_i && unit_if.cmp_result;
    end else if (wb_ready_i) begin
      // Bubble, only the valid changes
      wb_valid_o <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (xfer) begin
      wb_rf_waddr_o <= rf_waddr_i;
      wb_rf_wdata_o <= wdata_sel;
      wb_pc_o       <= pc_i;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/ex_stage.sv ====
/*
  Execute stage top level
  Takes one decoded instruction per transfer, ALU in one cycle,
  multiply in two; result goes to the EX/WB register on wb_ready_i
  Decode must hold its inputs until ex_ready_o
  No divider, CSR, load/store or system instruction support
*/

`default_nettype none

module ex_stage import ex_pkg::*; #(
  parameter int unsigned XLEN = 32
) (
  input  logic                 clk,
  input  logic                 rst_n,

  // From decode
  input  logic                 id_valid_i,
  input  logic                 alu_en_i,
  input  logic                 mul_en_i,
  input  alu_op_e              alu_op_i,
  input  mul_op_e              mul_op_i,
  input  logic [XLEN-1:0]      operand_a_i,
  input  logic [XLEN-1:0]      operand_b_i,
  input  logic                 alu_bch_i,
  input  logic                 rf_we_i,
  input  logic [REGADDR_W-1:0] rf_waddr_i,
  input  logic [XLEN-1:0]      pc_i,
  input  logic                 illegal_i,

  // From controller
  input  logic                 kill_i,
  input  logic                 halt_i,

  // Stage handshake
  input  logic                 wb_ready_i,
  output logic                 ex_ready_o,
  output logic                 ex_valid_o,

  // To fetch and decode
  output logic                 branch_decision_o,
  output logic [XLEN-1:0]      rf_wdata_o,

  // EX/WB register
  output logic                 wb_valid_o,
  output logic                 wb_rf_we_o,
  output logic [REGADDR_W-1:0] wb_rf_waddr_o,
  output logic [XLEN-1:0]      wb_rf_wdata_o,
  output logic [XLEN-1:0]      wb_pc_o,
  output logic                 wb_illegal_o,
  output logic                 wb_bch_taken_o
);

  logic mul_start;

  ex_unit_if #(.XLEN(XLEN)) unit_if ();

  ////////////////////
  // Control
  ////////////////////

  ex_ctrl u_ctrl (
    .id_valid_i  (id_valid_i),
    .alu_en_i    (alu_en_i),
    .mul_en_i    (mul_en_i),
    .illegal_i   (illegal_i),
    .kill_i      (kill_i),
    .halt_i      (halt_i),
    .wb_ready_i  (wb_ready_i),
    .mul_start_o (mul_start),
    .ex_valid_o  (ex_valid_o),
    .ex_ready_o  (ex_ready_o),
    .unit_if     (unit_if.ctrl)
  );

  ////////////////////
  // Functional units
  ////////////////////

  ex_alu #(.XLEN(XLEN)) u_alu (
    .op_i        (alu_op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .unit_if     (unit_if.alu)
  );

  ex_mult #(.XLEN(XLEN)) u_mult (
    .clk         (clk),
    .rst_n       (rst_n),
    .op_i        (mul_op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .start_i     (mul_start),
    .ready_i     (wb_ready_i),
    .kill_i      (kill_i),
    .unit_if     (unit_if.mult)
  );

  // Branch decision straight from the comparator
  assign branch_decision_o = unit_if.cmp_result;

  ////////////////////
  // EX/WB
  ////////////////////

  ex_wb_reg #(.XLEN(XLEN)) u_wb_reg (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_valid_i     (ex_valid_o),
    .wb_ready_i     (wb_ready_i),
    .mul_en_i       (mul_en_i),
    .illegal_i      (illegal_i),
    .alu_bch_i      (alu_bch_i),
    .rf_we_i        (rf_we_i),
    .rf_waddr_i     (rf_waddr_i),
    .pc_i           (pc_i),
    .unit_if        (unit_if.wb),
    .rf_wdata_o     (rf_wdata_o),
    .wb_valid_o     (wb_valid_o),
    .wb_rf_we_o     (wb_rf_we_o),
    .wb_rf_waddr_o  (wb_rf_waddr_o),
    .wb_rf_wdata_o  (wb_rf_wdata_o),
    .wb_pc_o        (wb_pc_o),
    .wb_illegal_o   (wb_illegal_o),
    .wb_bch_taken_o (wb_bch_taken_o)
  );

endmodule

`default_nettype wire

// ==== dv/ex_stage_sva.sv ====
/*
  Concurrent checks on the EX/WB handshake, bound to ex_stage
  Payload stability is only checked while wb_valid_o is high
*/

`default_nettype none

module ex_stage_sva import ex_pkg::*; #(
  parameter int unsigned XLEN = 32
) (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 kill_i,
  input logic                 wb_ready_i,
  input logic                 ex_valid_o,
  input logic                 wb_valid_o,
  input logic                 wb_rf_we_o,
  input logic [REGADDR_W-1:0] wb_rf_waddr_o,
  input logic [XLEN-1:0]      wb_rf_wdata_o,
  input logic [XLEN-1:0]      wb_pc_o,
  input logic                 wb_illegal_o,
  input logic                 wb_bch_taken_o
);

  // Count of failed properties
  int unsigned err_count = 0;

  // No valid result leaves EX/WB during reset
  a_reset_valid : assert property (@(posedge clk) !rst_n |-> !wb_valid_o)
    else begin
      err_count++;
      $error("wb_valid_o high during reset");
    end

  // WB stalled, status bits hold
  a_hold_status : assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready_i |=> $stable(wb_valid_o) && $stable(wb_rf_we_o) &&
                    $stable(wb_illegal_o) && $stable(wb_bch_taken_o))
    else begin
      err_count++;
      $error("wb status changed while wb_ready_i low");
    end

  // WB stalled on a valid result, payload holds
  a_hold_payload : assert property (@(posedge clk) disable iff (!rst_n)
    (!wb_ready_i && wb_valid_o) |=> $stable(wb_rf_waddr_o) &&
                                    $stable(wb_rf_wdata_o) && $stable(wb_pc_o))
    else begin
      err_count++;
      $error("wb payload changed while wb_ready_i low");
    end

  // A killed instruction never counts as valid
  // With WB ready the slot after the kill is a bubble
  a_kill_valid : assert property (@(posedge clk) disable iff (!rst_n)
    kill_i |-> !ex_valid_o ##1 (!wb_valid_o || !$past(wb_ready_i)))
    else begin
      err_count++;
      $error("killed instruction valid in EX or WB");
    end

endmodule

bind ex_stage ex_stage_sva #(.XLEN(XLEN)) u_sva (
  .clk            (clk),
  .rst_n          (rst_n),
  .kill_i         (kill_i),
  .wb_ready_i     (wb_ready_i),
  .ex_valid_o     (ex_valid_o),
  .wb_valid_o     (wb_valid_o),
  .wb_rf_we_o     (wb_rf_we_o),
  .wb_rf_waddr_o  (wb_rf_waddr_o),
  .wb_rf_wdata_o  (wb_rf_wdata_o),
  .wb_pc_o        (wb_pc_o),
  .wb_illegal_o   (wb_illegal_o),
  .wb_bch_taken_o (wb_bch_taken_o)
);

`default_nettype wire

// ==== dv/ex_stage_tb.sv ====
/*
  Directed testbench of the execute stage, XLEN fixed at 32
  Inputs change 1 time unit after the rising edge
  Combinational outputs are checked 1 unit later, registered ones
  right after the edge that updates them
*/

`default_nettype none

module ex_stage_tb import ex_pkg::*;;

  localparam int unsigned XLEN       = 32;
  localparam int unsigned MAX_CYCLES = 2000;

  logic                 clk;
  logic                 rst_n;
  logic                 id_valid_i;
  logic                 alu_en_i;
  logic                 mul_en_i;
  alu_op_e              alu_op_i;
  mul_op_e              mul_op_i;
  logic [XLEN-1:0]      operand_a_i;
  logic [XLEN-1:0]      operand_b_i;
  logic                 alu_bch_i;
  logic                 rf_we_i;
  logic [REGADDR_W-1:0] rf_waddr_i;
  logic [XLEN-1:0]      pc_i;
  logic                 illegal_i;
  logic                 kill_i;
  logic                 halt_i;
  logic                 wb_ready_i;
  logic                 ex_ready_o;
  logic                 ex_valid_o;
  logic                 branch_decision_o;
  logic [XLEN-1:0]      rf_wdata_o;
  logic                 wb_valid_o;
  logic                 wb_rf_we_o;
  logic [REGADDR_W-1:0] wb_rf_waddr_o;
  logic [XLEN-1:0]      wb_rf_wdata_o;
  logic [XLEN-1:0]      wb_pc_o;
  logic                 wb_illegal_o;
  logic                 wb_bch_taken_o;

  int unsigned cycle_cnt = 0;

  // Snapshot of the WB outputs taken before a stall
  logic                 held_valid;
  logic                 held_we;
  logic [REGADDR_W-1:0] held_waddr;
  logic [XLEN-1:0]      held_wdata;
  logic [XLEN-1:0]      held_pc;
  logic                 held_illegal;
  logic                 held_bch;

  ex_stage #(.XLEN(XLEN)) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles", cycle_cnt);
      $display("test failed");
      $fatal(1, "run did not finish in time");
    end
  end

  ////////////////////
  // Reference model
  ////////////////////

  function automatic logic signed_less(input logic [31:0] a, input logic [31:0] b);
    // Different signs decide at once
    return (a[31] != b[31]) ? a[31] : (a < b);
  endfunction

  function automatic logic model_cmp(input alu_op_e op, input logic [31:0] a,
                                     input logic [31:0] b);
    case (op)
      ALU_EQ:  return a == b;
      ALU_NE:  return a != b;
      ALU_LT:  return signed_less(a, b);
      ALU_GE:  return !signed_less(a, b);
      ALU_LTU: return a < b;
      ALU_GEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] model_alu(input alu_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
    logic [4:0]  sh;
    logic [31:0] res;
    sh = b[4:0];
    case (op)
      ALU_ADD:  res = a + b;
      ALU_SUB:  res = a + ~b + 32'd1;
      ALU_AND:  res = a & b;
      ALU_OR:   res = a | b;
      ALU_XOR:  res = a ^ b;
      ALU_SLL:  res = a << sh;
      ALU_SRL:  res = a >> sh;
      // Fill the vacated top bits with the sign
      ALU_SRA:  res = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
      ALU_SLT:  res = {31'b0, signed_less(a, b)};
      ALU_SLTU: res = {31'b0, a < b};
      default:  res = {31'b0, model_cmp(op, a, b)};
    endcase
    return res;
  endfunction

  // Extend each operand to 64 bits, product modulo 2^64
  function automatic logic [31:0] model_mul(input mul_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
    logic [63:0] a64;
    logic [63:0] b64;
    logic [63:0] prod;
    a64  = (op == MUL_HU) ? {32'h0, a} : {{32{a[31]}}, a};
    b64  = (op == MUL_LO || op == MUL_H) ? {{32{b[31]}}, b} : {32'h0, b};
    prod = a64 * b64;
    return (op == MUL_LO) ? prod[31:0] : prod[63:32];
  endfunction

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_bit(input string name, input logic exp, input logic act);
    assert (act === exp) else begin
      $display("ERR t=%0t %s expected=%0b actual=%0b", $time, name, exp, act);
      $display("test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic match_word(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERR t=%0t %s expected=%08h actual=%08h", $time, name, exp, act);
      $display("test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic clear_instr();
    id_valid_i  = 1'b0;
    alu_en_i    = 1'b0;
    mul_en_i    = 1'b0;
    alu_op_i    = ALU_ADD;
    mul_op_i    = MUL_LO;
    operand_a_i = '0;
    operand_b_i = '0;
    alu_bch_i   = 1'b0;
    rf_we_i     = 1'b0;
    rf_waddr_i  = '0;
    pc_i        = '0;
    illegal_i   = 1'b0;
  endtask

  task automatic present_alu(input alu_op_e op, input logic [31:0] a,
                             input logic [31:0] b, input logic bch);
    id_valid_i  = 1'b1;
    alu_en_i    = 1'b1;
    mul_en_i    = 1'b0;
    illegal_i   = 1'b0;
    alu_op_i    = op;
    operand_a_i = a;
    operand_b_i = b;
    alu_bch_i   = bch;
    rf_we_i     = 1'b1;
    rf_waddr_i  = REGADDR_W'($urandom);
    pc_i        = $urandom;
  endtask

  task automatic present_mul(input mul_op_e op, input logic [31:0] a, input logic [31:0] b);
    id_valid_i  = 1'b1;
    alu_en_i    = 1'b0;
    mul_en_i    = 1'b1;
    illegal_i   = 1'b0;
    mul_op_i    = op;
    operand_a_i = a;
    operand_b_i = b;
    alu_bch_i   = 1'b0;
    rf_we_i     = 1'b1;
    rf_waddr_i  = REGADDR_W'($urandom);
    pc_i        = $urandom;
  endtask

  // WB contents after a transfer of the instruction still on the inputs
  // alu_bch_i is low for all of them, so no taken flag
  task automatic check_wb(input logic [31:0] exp_data, input logic exp_we);
    check_bit("wb_valid_o", 1'b1, wb_valid_o);
    check_bit("wb_rf_we_o", exp_we, wb_rf_we_o);
    check_bit("wb_illegal_o", 1'b0, wb_illegal_o);
    check_bit("wb_bch_taken_o", 1'b0, wb_bch_taken_o);
    match_word("wb_rf_wdata_o", exp_data, wb_rf_wdata_o);
    match_word("wb_rf_waddr_o", 32'(rf_waddr_i), 32'(wb_rf_waddr_o));
    match_word("wb_pc_o", pc_i, wb_pc_o);
  endtask

  task automatic save_wb();
    held_valid   = wb_valid_o;
    held_we      = wb_rf_we_o;
    held_waddr   = wb_rf_waddr_o;
    held_wdata   = wb_rf_wdata_o;
    held_pc      = wb_pc_o;
    held_illegal = wb_illegal_o;
    held_bch     = wb_bch_taken_o;
  endtask

  task automatic verify_wb_held();
    check_bit("wb_valid_o", held_valid, wb_valid_o);
    check_bit("wb_rf_we_o", held_we, wb_rf_we_o);
    check_bit("wb_illegal_o", held_illegal, wb_illegal_o);
    check_bit("wb_bch_taken_o", held_bch, wb_bch_taken_o);
    match_word("wb_rf_waddr_o", 32'(held_waddr), 32'(wb_rf_waddr_o));
    match_word("wb_rf_wdata_o", held_wdata, wb_rf_wdata_o);
    match_word("wb_pc_o", held_pc, wb_pc_o);
  endtask

  ////////////////////
  // Tests
  ////////////////////

  // Every ALU operator, one instruction per cycle
  task automatic alu_op_sweep();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp;
    for (int k = 0; k < 16; k++) begin
      for (int i = 0; i < 20; i++) begin
        a = $urandom;
        b = (i == 0) ? a : $urandom;
        exp = model_alu(alu_op_e'(k), a, b);
        present_alu(alu_op_e'(k), a, b, 1'b0);
        #1;
        match_word("rf_wdata_o", exp, rf_wdata_o);
        check_bit("ex_valid_o", 1'b1, ex_valid_o);
        check_bit("ex_ready_o", 1'b1, ex_ready_o);
        tick();
        check_wb(exp, 1'b1);
      end
    end
  endtask

  task automatic branch_sweep();
    logic [31:0] a;
    logic [31:0] b;
    logic        taken;
    for (int k = ALU_EQ; k <= ALU_GEU; k++) begin
      for (int i = 0; i < 10; i++) begin
        a = $urandom;
        b = $urandom;
        // Equal pair, then a pair of opposite signs
        if (i == 0) b = a;
        if (i == 1) begin
          a = a | 32'h8000_0000;
          b = b & 32'h7fff_ffff;
        end
        taken = model_cmp(alu_op_e'(k), a, b);
        present_alu(alu_op_e'(k), a, b, 1'b1);
        #1;
        check_bit("branch_decision_o", taken, branch_decision_o);
        tick();
        check_bit("wb_valid_o", 1'b1, wb_valid_o);
        check_bit("wb_bch_taken_o", taken, wb_bch_taken_o);
      end
    end
  endtask

  task automatic mul_sweep();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp;
    for (int k = 0; k < 4; k++) begin
      for (int i = 0; i < 6; i++) begin
        a = (i == 0) ? 32'hffff_fffd : $urandom;
        b = (i == 0) ? 32'h8000_0007 : $urandom;
        exp = model_mul(mul_op_e'(k), a, b);
        present_mul(mul_op_e'(k), a, b);
        #1;
        check_bit("ex_ready_o", 1'b0, ex_ready_o);
        check_bit("ex_valid_o", 1'b0, ex_valid_o);
        tick();
        #1;
        check_bit("ex_valid_o", 1'b1, ex_valid_o);
        check_bit("ex_ready_o", 1'b1, ex_ready_o);
        match_word("rf_wdata_o", exp, rf_wdata_o);
        tick();
        check_wb(exp, 1'b1);
      end
    end
  endtask

  task automatic backpressure_test();
    logic [31:0] a;
    logic [31:0] b;
    a = $urandom;
    b = $urandom;
    // Known WB contents before the stall
    present_alu(ALU_XOR, a, b, 1'b0);
    tick();
    check_wb(model_alu(ALU_XOR, a, b), 1'b1);
    // Multiply held by WB
    a = $urandom;
    b = $urandom;
    present_mul(MUL_H, a, b);
    wb_ready_i = 1'b0;
    save_wb();
    for (int k = 0; k < 4; k++) begin
      #1;
      check_bit("ex_ready_o", 1'b0, ex_ready_o);
      check_bit("ex_valid_o", k != 0, ex_valid_o);
      tick();
      verify_wb_held();
    end
    wb_ready_i = 1'b1;
    #1;
    check_bit("ex_ready_o", 1'b1, ex_ready_o);
    tick();
    check_wb(model_mul(MUL_H, a, b), 1'b1);
    clear_instr();
    tick();
    check_bit("wb_valid_o", 1'b0, wb_valid_o);
    // ALU instruction held by WB
    present_alu(ALU_SRA, a, b, 1'b0);
    wb_ready_i = 1'b0;
    save_wb();
    for (int k = 0; k < 3; k++) begin
      #1;
      check_bit("ex_ready_o", 1'b0, ex_ready_o);
      check_bit("ex_valid_o", 1'b1, ex_valid_o);
      tick();
      verify_wb_held();
    end
    wb_ready_i = 1'b1;
    tick();
    check_wb(model_alu(ALU_SRA, a, b), 1'b1);
    clear_instr();
    tick();
    check_bit("wb_valid_o", 1'b0, wb_valid_o);
  endtask

  task automatic kill_halt_test();
    logic [31:0] a;
    logic [31:0] b;
    a = $urandom;
    b = $urandom;
    // Kill on an ALU instruction
    present_alu(ALU_ADD, a, b, 1'b0);
    kill_i = 1'b1;
    #1;
    check_bit("ex_ready_o", 1'b1, ex_ready_o);
    check_bit("ex_valid_o", 1'b0, ex_valid_o);
    tick();
    check_bit("wb_valid_o", 1'b0, wb_valid_o);
    // Kill in the second cycle of a multiply
    // WB stalled, so only the kill can free the FSM
    kill_i = 1'b0;
    present_mul(MUL_LO, a, b);
    tick();
    kill_i     = 1'b1;
    wb_ready_i = 1'b0;
    #1;
    check_bit("ex_ready_o", 1'b1, ex_ready_o);
    check_bit("ex_valid_o", 1'b0, ex_valid_o);
    tick();
    check_bit("wb_valid_o", 1'b0, wb_valid_o);
    kill_i     = 1'b0;
    wb_ready_i = 1'b1;
    // FSM back in idle, so the next multiply is busy in its first cycle
    present_mul(MUL_HU, a, b);
    #1;
    check_bit("ex_ready_o", 1'b0, ex_ready_o);
    tick();
    #1;
    check_bit("ex_valid_o", 1'b1, ex_valid_o);
    tick();
    check_wb(model_mul(MUL_HU, a, b), 1'b1);
    // Halt stalls with valid and ready low
    present_alu(ALU_OR, a, b, 1'b0);
    halt_i = 1'b1;
    #1;
    check_bit("ex_ready_o", 1'b0, ex_ready_o);
    check_bit("ex_valid_o", 1'b0, ex_valid_o);
    tick();
    check_bit("wb_valid_o", 1'b0, wb_valid_o);
    halt_i = 1'b0;
    clear_instr();
  endtask

  task automatic illegal_test();
    clear_instr();
    id_valid_i = 1'b1;
    illegal_i  = 1'b1;
    rf_we_i    = 1'b1;
    rf_waddr_i = 5'd9;
    pc_i       = $urandom;
    #1;
    check_bit("ex_valid_o", 1'b1, ex_valid_o);
    tick();
    check_bit("wb_valid_o", 1'b1, wb_valid_o);
    check_bit("wb_illegal_o", 1'b1, wb_illegal_o);
    check_bit("wb_rf_we_o", 1'b0, wb_rf_we_o);
    match_word("wb_pc_o", pc_i, wb_pc_o);
    clear_instr();
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    void'($urandom(32'h8900ebc5));
    rst_n      = 1'b0;
    kill_i     = 1'b0;
    halt_i     = 1'b0;
    wb_ready_i = 1'b1;
    clear_instr();
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_bit("wb_valid_o", 1'b0, wb_valid_o);
    check_bit("wb_rf_we_o", 1'b0, wb_rf_we_o);
    check_bit("wb_bch_taken_o", 1'b0, wb_bch_taken_o);
    check_bit("wb_illegal_o", 1'b0, wb_illegal_o);
    alu_op_sweep();
    branch_sweep();
    mul_sweep();
    backpressure_test();
    kill_halt_test();
    illegal_test();
    tick();
    if (u_dut.u_sva.err_count == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("Bound assertions failed %0d times", u_dut.u_sva.err_count);
      $display("test failed");
      $fatal(1, "assertion failures");
    end
  end

endmodule

`default_nettype wire

// ==== all.f ====
hdl/ex_pkg.sv
hdl/ex_unit_if.sv
hdl/ex_alu.sv
hdl/ex_mult.sv
hdl/ex_ctrl.sv
hdl/ex_wb_reg.sv
hdl/ex_stage.sv
dv/ex_stage_sva.sv
dv/ex_stage_tb.sv
